//--- hw/best_match.sv
`default_nettype none

module best_match (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 valid_i,
    input  patch_pkg::sad_t     sad_i,
    input  wire                 last_i,
    output logic                best_valid_o,
    output patch_pkg::sad_t     best_sad_o,
    output patch_pkg::idx_t     best_idx_o
);

    patch_pkg::idx_t    cnt_q;          // Index of the next candidate in the batch
    patch_pkg::sad_t    min_sad_q;
    patch_pkg::idx_t    min_idx_q;
    logic               better;
    patch_pkg::sad_t    new_sad;
    patch_pkg::idx_t    new_idx;

    // Strictly lower wins, so ties keep the earlier candidate
    assign better  = (cnt_q == '0) || (sad_i < min_sad_q);
    assign new_sad = better ? sad_i : min_sad_q;
    assign new_idx = better ? cnt_q : min_idx_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cnt_q        <= '0;
            best_valid_o <= 1'b0;
        end else begin
            best_valid_o <= valid_i && last_i;
            if (valid_i) begin
                cnt_q <= last_i ? '0 : cnt_q + 1'b1;    // Batch restarts after last
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_i) begin
            min_sad_q <= new_sad;
            min_idx_q <= new_idx;
            if (last_i) begin
                best_sad_o <= new_sad;
                best_idx_o <= new_idx;
            end
        end
    end

    a_valid_pulse : assert property (
        @(posedge clk) disable iff (rst_i)
        best_valid_o |=> !best_valid_o
    ) else $error("best_valid_o held longer than one cycle");

endmodule

`default_nettype wire

//--- hw/patch_match_top.sv
`default_nettype none

module patch_match_top (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 wb_mode_i,
    // Wishbone slave
    input  wire                 wbs_stb_i,
    input  wire                 wbs_cyc_i,
    input  wire                 wbs_we_i,
    input  wire  [3:0]          wbs_sel_i,
    input  wire  [31:0]         wbs_dat_i,
    input  wire  [31:0]         wbs_adr_i,
    output logic                wbs_ack_o,
    output logic [31:0]         wbs_dat_o,
    // Native patch write
    input  wire                 patch_we_i,
    input  patch_pkg::addr_t    patch_addr_i,
    input  patch_pkg::patch_t   patch_wdata_i,
    // Four-phase candidate stream
    input  wire                 cand_req_i,
    input  patch_pkg::addr_t    cand_qaddr_i,
    input  patch_pkg::patch_t   cand_patch_i,
    input  wire                 cand_last_i,
    output logic                cand_ack_o,
    // Result
    output logic                best_valid_o,
    output patch_pkg::sad_t     best_sad_o,
    output patch_pkg::idx_t     best_idx_o
);

    patch_pkg::ack_state_t  state_q;
    logic                   accept;
    logic                   cand_valid_q;
    patch_pkg::patch_t      cand_patch_q;
    logic                   cand_last_q;
    patch_pkg::patch_t      query_patch;
    logic                   sad_valid;
    patch_pkg::sad_t        sad;
    logic                   sad_last;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= patch_pkg::IDLE;
        end else begin
            case (state_q)
                patch_pkg::IDLE:     if (cand_req_i) state_q <= patch_pkg::ACK;
                patch_pkg::ACK:      state_q <= patch_pkg::WAIT_LOW;
                patch_pkg::WAIT_LOW: if (!cand_req_i) state_q <= patch_pkg::IDLE;
                default:             state_q <= patch_pkg::IDLE;
            endcase
        end
    end

    assign cand_ack_o = (state_q != patch_pkg::IDLE);
    assign accept     = (state_q == patch_pkg::ACK);   // First ack cycle

    // Candidate data waits one cycle for the RAM read
    always_ff @(posedge clk) begin
        if (rst_i) begin
            cand_valid_q <= 1'b0;
        end else begin
            cand_valid_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cand_patch_q <= cand_patch_i;
            cand_last_q  <= cand_last_i;
        end
    end

    query_patch_mem query_patch_mem_inst (
        .clk(clk), .rst_i(rst_i), .wb_mode_i(wb_mode_i),
        .wbs_stb_i(wbs_stb_i), .wbs_cyc_i(wbs_cyc_i), .wbs_we_i(wbs_we_i),
        .wbs_sel_i(wbs_sel_i), .wbs_dat_i(wbs_dat_i), .wbs_adr_i(wbs_adr_i),
        .wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
        .patch_we_i(patch_we_i), .patch_addr_i(patch_addr_i),
        .patch_wdata_i(patch_wdata_i),
        .rd_en_i(accept), .rd_addr_i(cand_qaddr_i), .rd_patch_o(query_patch)
    );

    patch_sad patch_sad_inst (
        .clk(clk), .rst_i(rst_i),
        .valid_i(cand_valid_q), .query_i(query_patch), .cand_i(cand_patch_q),
        .last_i(cand_last_q),
        .valid_o(sad_valid), .sad_o(sad), .last_o(sad_last)
    );

    best_match best_match_inst (
        .clk(clk), .rst_i(rst_i),
        .valid_i(sad_valid), .sad_i(sad), .last_i(sad_last),
        .best_valid_o(best_valid_o), .best_sad_o(best_sad_o), .best_idx_o(best_idx_o)
    );

endmodule

`default_nettype wire

//--- hw/patch_pkg.sv
`default_nettype none

package patch_pkg;

    // Patch geometry
    localparam int PIX_W   = 11;
    localparam int PATCH_N = 5;
    localparam int PATCH_W = PIX_W * PATCH_N;   // 55 bits per query patch

    // RAM organisation
    localparam int RAM_W  = 64;
    localparam int MASK_W = RAM_W / 8;          // One mask bit per byte lane
    localparam int ADDR_W = 9;
    localparam int DEPTH  = 512;

    // Wishbone base of the patch window
    localparam int unsigned WB_OFFSET = 557;

    localparam int SAD_W = 14;                  // Holds 5 * 2047
    localparam int IDX_W = 8;

    typedef logic [PIX_W-1:0]   pixel_t;
    typedef logic [PATCH_W-1:0] patch_t;
    typedef logic [RAM_W-1:0]   word_t;
    typedef logic [MASK_W-1:0]  mask_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [SAD_W-1:0]   sad_t;
    typedef logic [IDX_W-1:0]   idx_t;

    // Candidate req/ack controller
    typedef enum logic [1:0] {IDLE, ACK, WAIT_LOW} ack_state_t;

endpackage

`default_nettype wire

//--- hw/patch_sad.sv
`default_nettype none

module patch_sad (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 valid_i,
    input  patch_pkg::patch_t   query_i,
    input  patch_pkg::patch_t   cand_i,
    input  wire                 last_i,
    output logic                valid_o,
    output patch_pkg::sad_t     sad_o,
    output logic                last_o
);

    patch_pkg::pixel_t  diff_q [patch_pkg::PATCH_N];
    logic               valid_q;
    logic               last_q;
    patch_pkg::sad_t    diff_sum;

    // Stage 1 registers the absolute difference of each pixel
    always_ff @(posedge clk) begin
        for (int i = 0; i < patch_pkg::PATCH_N; i++) begin
            if (query_i[i*patch_pkg::PIX_W +: patch_pkg::PIX_W] >
                cand_i[i*patch_pkg::PIX_W +: patch_pkg::PIX_W]) begin
                diff_q[i] <= query_i[i*patch_pkg::PIX_W +: patch_pkg::PIX_W] -
                             cand_i[i*patch_pkg::PIX_W +: patch_pkg::PIX_W];
            end else begin
                diff_q[i] <= cand_i[i*patch_pkg::PIX_W +: patch_pkg::PIX_W] -
                             query_i[i*patch_pkg::PIX_W +: patch_pkg::PIX_W];
            end
        end
    end

    always_comb begin
        diff_sum = '0;
        for (int i = 0; i < patch_pkg::PATCH_N; i++) begin
            diff_sum = diff_sum + patch_pkg::sad_t'(diff_q[i]);
        end
    end

    // Stage 2 registers the sum
    always_ff @(posedge clk) begin
        sad_o <= diff_sum;
    end

    // Valid and last follow the data through both stages
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
            valid_o <= 1'b0;
            last_o  <= 1'b0;
        end else begin
            valid_q <= valid_i;
            last_q  <= last_i;
            valid_o <= valid_q;
            last_o  <= last_q;
        end
    end

endmodule

`default_nettype wire

//--- hw/query_patch_mem.sv
`default_nettype none

module query_patch_mem (
    input  wire                 clk,
    input  wire                 rst_i,
    input  wire                 wb_mode_i,      // Wishbone owns port 0 when high
    // Wishbone slave
    input  wire                 wbs_stb_i,
    input  wire                 wbs_cyc_i,
    input  wire                 wbs_we_i,
    input  wire  [3:0]          wbs_sel_i,
    input  wire  [31:0]         wbs_dat_i,
    input  wire  [31:0]         wbs_adr_i,
    output logic                wbs_ack_o,
    output logic [31:0]         wbs_dat_o,
    // Native patch write
    input  wire                 patch_we_i,
    input  patch_pkg::addr_t    patch_addr_i,
    input  patch_pkg::patch_t   patch_wdata_i,
    // Pipeline read
    input  wire                 rd_en_i,
    input  patch_pkg::addr_t    rd_addr_i,
    output patch_pkg::patch_t   rd_patch_o
);

    logic               wb_req;
    logic               wb_wr;
    patch_pkg::addr_t   wb_addr;
    logic [2:0]         wb_lane;
    patch_pkg::mask_t   wb_mask;
    patch_pkg::word_t   wb_wdata;
    patch_pkg::word_t   io_wdata;

    logic               csb0;
    logic               web0;
    patch_pkg::mask_t   wmask0;
    patch_pkg::addr_t   addr0;
    patch_pkg::word_t   din0;
    patch_pkg::word_t   dout0;
    patch_pkg::word_t   dout1;

    logic               ack_pend;
    logic               half_sel_q;

    assign wb_req = wbs_stb_i && wbs_cyc_i;
    assign wb_wr  = wbs_we_i && wbs_sel_i[0];   // Data byte rides in bus lane 0

    // Byte lane comes from data bits 13..11 rather than the address
    assign wb_addr  = patch_pkg::addr_t'(wbs_adr_i - 32'(patch_pkg::WB_OFFSET));
    assign wb_lane  = wbs_dat_i[13:11];
    assign wb_mask  = patch_pkg::mask_t'(1) << wb_lane;
    assign wb_wdata = patch_pkg::word_t'(wbs_dat_i[7:0]) << {wb_lane, 3'b000};

    assign io_wdata = {{(patch_pkg::RAM_W - patch_pkg::PATCH_W){1'b0}}, patch_wdata_i};

    // Port 0 owner select
    always_comb begin
        if (wb_mode_i) begin
            csb0   = !wb_req;
            web0   = !wb_wr;
            wmask0 = wb_mask;
            addr0  = wb_addr;
            din0   = wb_wdata;
        end else begin
            csb0   = !patch_we_i;               // Native side only writes
            web0   = 1'b0;
            wmask0 = '1;
            addr0  = patch_addr_i;
            din0   = io_wdata;
        end
    end

    // Ack two cycles after the request and held until stb drops
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_pend  <= 1'b0;
            wbs_ack_o <= 1'b0;
        end else if (wb_req) begin
            ack_pend  <= 1'b1;
            wbs_ack_o <= ack_pend;
        end else begin
            ack_pend  <= 1'b0;
            wbs_ack_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req) begin
            half_sel_q <= wbs_dat_i[11];        // Picks the read half
        end
    end

    assign wbs_dat_o = half_sel_q ? {9'b0, dout0[54:32]} : dout0[31:0];

    assign rd_patch_o = dout1[patch_pkg::PATCH_W-1:0];

    sram_1kbyte_1rw1r ram_patch_inst (
        .clk    (clk),
        .csb0   (csb0),
        .web0   (web0),
        .wmask0 (wmask0),
        .addr0  (addr0),
        .din0   (din0),
        .dout0  (dout0),
        .csb1   (!rd_en_i),
        .addr1  (rd_addr_i),
        .dout1  (dout1)
    );

    // Ack needs a request that was live on both of the two previous edges
    a_ack_needs_stb : assert property (
        @(posedge clk) disable iff (rst_i)
        wbs_ack_o |-> ($past(wb_req) && $past(wb_req, 2))
    ) else $error("wbs_ack_o without wbs_stb_i");

endmodule

`default_nettype wire

//--- hw/sram_1kbyte_1rw1r.sv
`default_nettype none

module sram_1kbyte_1rw1r (
    input  wire                 clk,
    // Port 0 reads and writes
    input  wire                 csb0,       // Active low
    input  wire                 web0,       // Active low
    input  patch_pkg::mask_t    wmask0,
    input  patch_pkg::addr_t    addr0,
    input  patch_pkg::word_t    din0,
    output patch_pkg::word_t    dout0,
    // Port 1 only reads
    input  wire                 csb1,
    input  patch_pkg::addr_t    addr1,
    output patch_pkg::word_t    dout1
);

    patch_pkg::word_t mem [patch_pkg::DEPTH];

    // Port 0 writes only the lanes enabled in the mask
    always_ff @(posedge clk) begin
        if (!csb0) begin
            if (!web0) begin
                for (int b = 0; b < patch_pkg::MASK_W; b++) begin
                    if (wmask0[b]) begin
                        mem[addr0][b*8 +: 8] <= din0[b*8 +: 8];
                    end
                end
            end else begin
                dout0 <= mem[addr0];            // One cycle read latency
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!csb1) begin
            dout1 <= mem[addr1];
        end
    end

    // A masked write with nothing enabled points to a broken lane decode
    a_no_empty_write : assert property (
        @(posedge clk) (!csb0 && !web0) |-> (wmask0 != '0)
    ) else $error("port 0 write with empty mask");

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_patch_match -f sim.f \
    && ./obj_dir/Vtb_patch_match | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

//--- sim.f
+incdir+sim
hw/patch_pkg.sv
hw/sram_1kbyte_1rw1r.sv
hw/query_patch_mem.sv
hw/patch_sad.sv
hw/best_match.sv
hw/patch_match_top.sv
sim/tb_patch_match.sv

//--- sim/tb_bus_tasks.svh
// Waits for the Wishbone ack as sampled on the falling edge
task automatic wait_wb_ack(input logic level);
    int t;
    t = 0;
    while (wbs_ack_o !== level && t < WAIT_MAX) begin
        @(negedge clk);
        t++;
    end
    if (wbs_ack_o !== level) begin
        $display("ERROR at %0t: wbs_ack_o did not go to %0b within %0d cycles",
                 $time, level, WAIT_MAX);
        errors++;
    end
endtask

task automatic wait_cand_ack(input logic level);
    int t;
    t = 0;
    while (cand_ack_o !== level && t < WAIT_MAX) begin
        @(negedge clk);
        t++;
    end
    if (cand_ack_o !== level) begin
        $display("ERROR at %0t: cand_ack_o did not go to %0b within %0d cycles",
                 $time, level, WAIT_MAX);
        errors++;
    end
endtask

// One classic Wishbone cycle that captures data while ack is high
task automatic wb_cycle(input patch_pkg::addr_t a, input logic we, input logic [31:0] dat,
                        output logic [31:0] rdata);
    @(posedge clk);
    wbs_adr_i <= 32'(a) + 32'(patch_pkg::WB_OFFSET);
    wbs_dat_i <= dat;
    wbs_we_i  <= we;
    wbs_sel_i <= 4'b0001;
    wbs_stb_i <= 1'b1;
    wbs_cyc_i <= 1'b1;
    wait_wb_ack(1'b1);
    rdata = wbs_dat_o;
    @(posedge clk);
    wbs_stb_i <= 1'b0;
    wbs_cyc_i <= 1'b0;
    wbs_we_i  <= 1'b0;
    wait_wb_ack(1'b0);          // Ack falls the cycle after stb drops
endtask

task automatic wb_write(input patch_pkg::addr_t a, input logic [2:0] lane,
                        input logic [7:0] b);
    logic [31:0] unused;
    wb_cycle(a, 1'b1, {18'b0, lane, 3'b000, b}, unused);    // Lane sits in data bits 13..11
endtask

task automatic wb_read(input patch_pkg::addr_t a, input logic hi, output logic [31:0] d);
    wb_cycle(a, 1'b0, {20'b0, hi, 11'b0}, d);
endtask

task automatic write_patch(input patch_pkg::addr_t a, input patch_pkg::patch_t p);
    @(posedge clk);
    patch_we_i    <= 1'b1;
    patch_addr_i  <= a;
    patch_wdata_i <= p;
    @(posedge clk);
    patch_we_i <= 1'b0;
endtask

// Four-phase send whose data stays put until the next call
task automatic send_cand(input patch_pkg::addr_t qa, input patch_pkg::patch_t cp,
                         input logic last);
    @(posedge clk);
    cand_req_i   <= 1'b1;
    cand_qaddr_i <= qa;
    cand_patch_i <= cp;
    cand_last_i  <= last;
    wait_cand_ack(1'b1);
    ack_cyc = cyc;
    @(posedge clk);
    cand_req_i <= 1'b0;
    @(negedge clk);
    ack_held = cand_ack_o;      // Ack should outlive req by one cycle
    wait_cand_ack(1'b0);
endtask

//--- sim/tb_patch_match.sv
`default_nettype none

module tb_patch_match;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_MAX = 20;       // Longest any single wait may take in cycles
    localparam int N_USED   = 16;

    logic                clk = 1'b0;
    logic                rst_i = 1'b1;
    logic                wb_mode_i;
    logic                wbs_stb_i;
    logic                wbs_cyc_i;
    logic                wbs_we_i;
    logic [3:0]          wbs_sel_i;
    logic [31:0]         wbs_dat_i;
    logic [31:0]         wbs_adr_i;
    logic                wbs_ack_o;
    logic [31:0]         wbs_dat_o;
    logic                patch_we_i;
    patch_pkg::addr_t    patch_addr_i;
    patch_pkg::patch_t   patch_wdata_i;
    logic                cand_req_i;
    patch_pkg::addr_t    cand_qaddr_i;
    patch_pkg::patch_t   cand_patch_i;
    logic                cand_last_i;
    logic                cand_ack_o;
    logic                best_valid_o;
    patch_pkg::sad_t     best_sad_o;
    patch_pkg::idx_t     best_idx_o;

    patch_pkg::patch_t   shadow [patch_pkg::DEPTH];     // Memory model
    patch_pkg::addr_t    used_addr [N_USED];
    patch_pkg::addr_t    b_addr [8];
    patch_pkg::patch_t   b_patch [8];
    patch_pkg::sad_t     b_sad [8];
    patch_pkg::sad_t     exp_sad_q [$];
    patch_pkg::idx_t     exp_idx_q [$];
    logic [31:0]         lcg_state = 32'h2f3;
    int                  cyc = 0;
    int                  ack_cyc = 0;
    int                  best_cyc = 0;
    logic                ack_held = 1'b0;
    int                  tests = 0;
    int                  checks = 0;
    int                  errors = 0;

    `include "tb_bus_tasks.svh"

    initial begin
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    patch_match_top patch_match_top_inst (
        .clk(clk), .rst_i(rst_i), .wb_mode_i(wb_mode_i),
        .wbs_stb_i(wbs_stb_i), .wbs_cyc_i(wbs_cyc_i), .wbs_we_i(wbs_we_i),
        .wbs_sel_i(wbs_sel_i), .wbs_dat_i(wbs_dat_i), .wbs_adr_i(wbs_adr_i),
        .wbs_ack_o(wbs_ack_o), .wbs_dat_o(wbs_dat_o),
        .patch_we_i(patch_we_i), .patch_addr_i(patch_addr_i), .patch_wdata_i(patch_wdata_i),
        .cand_req_i(cand_req_i), .cand_qaddr_i(cand_qaddr_i), .cand_patch_i(cand_patch_i),
        .cand_last_i(cand_last_i), .cand_ack_o(cand_ack_o),
        .best_valid_o(best_valid_o), .best_sad_o(best_sad_o), .best_idx_o(best_idx_o)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 16);      // Fold the better high bits down
    endfunction

    function automatic patch_pkg::patch_t rand_patch();
        logic [63:0] r;
        r[31:0]  = lcg_next();
        r[63:32] = lcg_next();
        return r[patch_pkg::PATCH_W-1:0];
    endfunction

    // Sum of absolute pixel differences
    function automatic patch_pkg::sad_t ref_sad(input patch_pkg::patch_t q,
                                                input patch_pkg::patch_t c);
        int sum;
        int qp;
        int cp;
        sum = 0;
        for (int i = 0; i < patch_pkg::PATCH_N; i++) begin
            qp = int'(q[i*patch_pkg::PIX_W +: patch_pkg::PIX_W]);
            cp = int'(c[i*patch_pkg::PIX_W +: patch_pkg::PIX_W]);
            sum += (qp > cp) ? qp - cp : cp - qp;
        end
        return patch_pkg::sad_t'(sum);
    endfunction

    function automatic logic [31:0] ref_rd_word(input patch_pkg::patch_t p, input logic hi);
        return hi ? {9'b0, p[54:32]} : p[31:0];
    endfunction

    function automatic patch_pkg::patch_t ref_byte_write(input patch_pkg::patch_t p,
                                                         input logic [2:0] lane,
                                                         input logic [7:0] b);
        patch_pkg::word_t w;
        w = patch_pkg::word_t'(p);
        w[int'(lane)*8 +: 8] = b;
        return w[patch_pkg::PATCH_W-1:0];       // Bits above 54 never reach a patch
    endfunction

    // Lowest SAD of the batch where the first one wins a tie
    function automatic patch_pkg::idx_t ref_best(input int n, output patch_pkg::sad_t bsad);
        patch_pkg::idx_t bidx;
        bsad = b_sad[0];
        bidx = '0;
        for (int j = 1; j < n; j++) begin
            if (b_sad[j] < bsad) begin
                bsad = b_sad[j];
                bidx = patch_pkg::idx_t'(j);
            end
        end
        return bidx;
    endfunction

    task automatic check_sad(input patch_pkg::sad_t got, input patch_pkg::sad_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: best_sad_o got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_idx(input patch_pkg::idx_t got, input patch_pkg::idx_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: best_idx_o got %0d expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: wbs_dat_o got %08h expected %08h", $time, got, exp);
        end
    endtask

    task automatic wait_results();
        int t;
        t = 0;
        while (exp_sad_q.size() != 0 && t < WAIT_MAX) begin
            @(negedge clk);
            t++;
        end
        if (exp_sad_q.size() != 0) begin
            $display("ERROR at %0t: %0d batch results never arrived", $time, exp_sad_q.size());
            errors++;
            exp_sad_q.delete();
            exp_idx_q.delete();
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - err_start);
        end
    endtask

    // Every result pulse is checked against the oldest expected batch
    always @(negedge clk) begin
        if (!rst_i && best_valid_o === 1'b1) begin
            best_cyc = cyc;
            if (exp_sad_q.size() == 0) begin
                $display("ERROR at %0t: best_valid_o pulsed with no batch pending", $time);
                errors++;
            end else begin
                check_sad(best_sad_o, exp_sad_q.pop_front());
                check_idx(best_idx_o, exp_idx_q.pop_front());
            end
        end
    end

    initial begin
        int                 err_start;
        int                 n;
        int                 k;
        logic [31:0]        rd;
        logic [2:0]         lane;
        logic [7:0]         bval;
        patch_pkg::addr_t   a;
        patch_pkg::patch_t  cand;
        patch_pkg::sad_t    exp_sad;
        patch_pkg::idx_t    exp_idx;

        wb_mode_i     = 1'b0;
        wbs_stb_i     = 1'b0;
        wbs_cyc_i     = 1'b0;
        wbs_we_i      = 1'b0;
        wbs_sel_i     = 4'b0000;
        wbs_dat_i     = '0;
        wbs_adr_i     = '0;
        patch_we_i    = 1'b0;
        patch_addr_i  = '0;
        patch_wdata_i = '0;
        cand_req_i    = 1'b0;
        cand_qaddr_i  = '0;
        cand_patch_i  = '0;
        cand_last_i   = 1'b0;
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        @(negedge clk);

        err_start = errors;
        if (cand_ack_o !== 1'b0 || wbs_ack_o !== 1'b0 || best_valid_o !== 1'b0) begin
            $display("ERROR at %0t: ack or result outputs not low after reset", $time);
            errors++;
        end
        report_test("outputs after reset", err_start);

        err_start = errors;
        for (int i = 0; i < N_USED; i++) begin
            used_addr[i] = patch_pkg::addr_t'(lcg_next());
            shadow[used_addr[i]] = rand_patch();
            write_patch(used_addr[i], shadow[used_addr[i]]);
        end
        @(posedge clk);
        wb_mode_i <= 1'b1;
        for (int i = 0; i < N_USED; i++) begin
            for (int h = 0; h < 2; h++) begin
                wb_read(used_addr[i], 1'(h), rd);
                check_word(rd, ref_rd_word(shadow[used_addr[i]], 1'(h)));
            end
        end
        report_test("native write with Wishbone readback", err_start);

        err_start = errors;
        for (int i = 0; i < 12; i++) begin
            a    = used_addr[lcg_next() % N_USED];
            lane = 3'(lcg_next());
            bval = 8'(lcg_next());
            wb_write(a, lane, bval);
            shadow[a] = ref_byte_write(shadow[a], lane, bval);
            for (int h = 0; h < 2; h++) begin
                wb_read(a, 1'(h), rd);
                check_word(rd, ref_rd_word(shadow[a], 1'(h)));
            end
        end
        report_test("Wishbone byte lane writes", err_start);

        err_start = errors;
        cand = rand_patch();
        exp_sad_q.push_back(ref_sad(shadow[used_addr[0]], cand));
        exp_idx_q.push_back(patch_pkg::idx_t'(0));
        send_cand(used_addr[0], cand, 1'b1);
        wait_results();
        if (best_cyc - ack_cyc != 4) begin
            $display("ERROR at %0t: best_valid_o came %0d cycles after cand_ack_o rose, not 4",
                     $time, best_cyc - ack_cyc);
            errors++;
        end
        if (ack_held !== 1'b1) begin
            $display("ERROR at %0t: cand_ack_o fell together with cand_req_i", $time);
            errors++;
        end
        report_test("single candidate and handshake", err_start);

        err_start = errors;
        for (int b = 0; b < 6; b++) begin
            n = 2 + int'(lcg_next() % 7);
            for (int j = 0; j < n; j++) begin
                if (j > 0 && lcg_next() % 3 == 0) begin
                    k = int'(lcg_next() % j);           // Repeat an earlier one to force a tie
                    b_addr[j]  = b_addr[k];
                    b_patch[j] = b_patch[k];
                end else begin
                    b_addr[j]  = used_addr[lcg_next() % N_USED];
                    b_patch[j] = rand_patch();
                end
                b_sad[j] = ref_sad(shadow[b_addr[j]], b_patch[j]);
            end
            exp_idx = ref_best(n, exp_sad);
            exp_sad_q.push_back(exp_sad);
            exp_idx_q.push_back(exp_idx);
            for (int j = 0; j < n; j++) begin
                send_cand(b_addr[j], b_patch[j], j == n - 1);
            end
        end
        wait_results();
        report_test("random batches", err_start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
